// ==== verilog/fpcast_fmt_pkg.sv ====
// Format constants for the binary32 <-> 32-bit integer cast unit
// Only IEEE binary32 and 32-bit integers are supported
`default_nettype none

package fpcast_fmt_pkg;

  // ---------------------------------------------------------------------
  // Float and integer formats
  // ---------------------------------------------------------------------
  localparam int unsigned FP_WIDTH  = 32;
  localparam int unsigned EXP_BITS  = 8;
  localparam int unsigned MAN_BITS  = 23;
  localparam int unsigned BIAS      = 127;
  localparam int unsigned INT_WIDTH = 32;

  // ---------------------------------------------------------------------
  // Internal number representation
  // ---------------------------------------------------------------------
  // Mantissa holds the implicit bit or a whole integer
  localparam int unsigned MAN_INT_WIDTH = (MAN_BITS + 1 > INT_WIDTH) ? MAN_BITS + 1 : INT_WIDTH;
  localparam int unsigned LZC_WIDTH     = $clog2(MAN_INT_WIDTH);
  // Signed exponent, wide enough for the smallest subnormal
  localparam int unsigned EXP_INT_WIDTH = 10;

  localparam logic [FP_WIDTH-1:0] FP_QNAN = 32'h7FC0_0000;  // Canonical quiet NaN

endpackage

`default_nettype wire

// ==== verilog/fpcast_op_pkg.sv ====
// Opcodes, rounding modes, status flags and stage payloads of the cast unit
// DZ is kept for compatibility and is always 0 here
`default_nettype none

package fpcast_op_pkg;

  typedef enum logic {
    F2I = 1'b0,  // Float to integer
    I2F = 1'b1   // Integer to float
  } cast_op_e;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } round_mode_e;

  typedef struct packed {
    logic NV;  // Invalid
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // ---------------------------------------------------------------------
  // Stage payloads
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic                                             sign;
    logic signed [fpcast_fmt_pkg::EXP_INT_WIDTH-1:0]  exp;      // Unbiased
    logic signed [fpcast_fmt_pkg::EXP_INT_WIDTH-1:0]  dst_exp;  // Rebiased for float
    logic        [fpcast_fmt_pkg::MAN_INT_WIDTH-1:0]  mant;     // Leading one at MSB
    logic                                             mant_zero;
    fp_info_t                                         info;
    cast_op_e                                         op;
    logic                                             is_unsigned;
    round_mode_e                                      rnd_mode;
  } norm_beat_t;

  typedef struct packed {
    logic                                 sign;
    logic [fpcast_fmt_pkg::EXP_BITS-1:0]  final_exp;
    logic [fpcast_fmt_pkg::INT_WIDTH-1:0] value;      // Integer or float mantissa
    logic [1:0]                           fp_rs;      // Round and sticky
    logic [1:0]                           int_rs;
    logic                                 of_before;
    logic                                 uf_before;
    fp_info_t                             info;
    logic                                 mant_zero;
    cast_op_e                             op;
    logic                                 is_unsigned;
    round_mode_e                          rnd_mode;
  } align_beat_t;

endpackage

`default_nettype wire

// ==== verilog/fpcast_stage_if.sv ====
// Valid/ready link between two pipeline stages
// A beat moves on a rising edge where valid and ready are both high
// The source keeps payload steady while valid is high and ready is low
`timescale 1ns/10ps
`default_nettype none

interface fpcast_stage_if #(
  parameter type payload_t = logic
);

  logic     valid;    // Source offers a beat
  payload_t payload;
  logic     ready;    // Sink takes the beat

  modport src (
    output valid,
    output payload,
    input  ready
  );

  modport dst (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== verilog/fpcast_lzc.sv ====
// Leading-zero counter for the internal mantissa
// The count is 0 for an all-zero input; check empty_o first
`timescale 1ns/10ps
`default_nettype none

module fpcast_lzc (
  input  logic [fpcast_fmt_pkg::MAN_INT_WIDTH-1:0] in_i,
  output logic [fpcast_fmt_pkg::LZC_WIDTH-1:0]     cnt_o,
  output logic                                     empty_o
);

  // Scan upwards so the highest set bit wins
  always_comb begin
    cnt_o = '0;
    for (int i = 0; i < int'(fpcast_fmt_pkg::MAN_INT_WIDTH); i++) begin
      if (in_i[i]) begin
        cnt_o = fpcast_fmt_pkg::LZC_WIDTH'(fpcast_fmt_pkg::MAN_INT_WIDTH - 1 - i);
      end
    end
  end

  assign empty_o = ~(|in_i);

endmodule

`default_nettype wire

// ==== verilog/fpcast_normalize.sv ====
// Input stage: request register, classification and normalization
// Integers are two's complement unless unsigned_i is set
// Exponent is rebiased for binary32 whatever the direction
`timescale 1ns/10ps
`default_nettype none

module fpcast_normalize (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  input  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] operand_i,
  input  fpcast_op_pkg::cast_op_e             op_i,
  input  logic                                unsigned_i,
  input  fpcast_op_pkg::round_mode_e          rnd_mode_i,
  fpcast_stage_if.src                         out_o
);

  logic                                valid_q;
  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] operand_q;
  fpcast_op_pkg::cast_op_e             op_q;
  logic                                unsigned_q;
  fpcast_op_pkg::round_mode_e          rnd_mode_q;

  // ---------------------------------------------------------------------
  // Input register
  // ---------------------------------------------------------------------
  assign in_ready_o = out_o.ready | ~valid_q;  // Slot empty or draining

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_ready_o && in_valid_i) begin
      operand_q  <= operand_i;
      op_q       <= op_i;
      unsigned_q <= unsigned_i;
      rnd_mode_q <= rnd_mode_i;
    end
  end

  // ---------------------------------------------------------------------
  // Classification and integer magnitude
  // ---------------------------------------------------------------------
  logic [fpcast_fmt_pkg::EXP_BITS-1:0]      exp_field;
  logic [fpcast_fmt_pkg::MAN_BITS-1:0]      man_field;
  fpcast_op_pkg::fp_info_t                  info;
  logic                                     is_normal;
  logic                                     src_is_int;
  logic                                     int_sign;
  logic [fpcast_fmt_pkg::MAN_INT_WIDTH-1:0] int_value, int_mant, fp_mant, enc_mant;

  assign exp_field = operand_q[fpcast_fmt_pkg::FP_WIDTH-2 -: fpcast_fmt_pkg::EXP_BITS];
  assign man_field = operand_q[fpcast_fmt_pkg::MAN_BITS-1:0];

  assign info.is_zero       = (exp_field == '0) && (man_field == '0);
  assign info.is_subnormal  = (exp_field == '0) && (man_field != '0);
  assign info.is_inf        = (exp_field == '1) && (man_field == '0);
  assign info.is_nan        = (exp_field == '1) && (man_field != '0);
  assign info.is_signalling = info.is_nan & ~man_field[fpcast_fmt_pkg::MAN_BITS-1];
  assign is_normal          = (exp_field != '0) && (exp_field != '1);

  assign src_is_int = (op_q == fpcast_op_pkg::I2F);
  assign int_value  = fpcast_fmt_pkg::MAN_INT_WIDTH'(operand_q);
  assign int_sign   = int_value[fpcast_fmt_pkg::MAN_INT_WIDTH-1] & ~unsigned_q;
  assign int_mant   = int_sign ? -int_value : int_value;  // Magnitude
  assign fp_mant    = fpcast_fmt_pkg::MAN_INT_WIDTH'({is_normal, man_field});
  assign enc_mant   = src_is_int ? int_mant : fp_mant;

  // ---------------------------------------------------------------------
  // Renormalization
  // ---------------------------------------------------------------------
  logic [fpcast_fmt_pkg::LZC_WIDTH-1:0]            shamt;
  logic                                            mant_zero;
  logic signed [fpcast_fmt_pkg::EXP_INT_WIDTH-1:0] fp_exp, int_exp, unb_exp;
  fpcast_op_pkg::norm_beat_t                       beat;

  fpcast_lzc i_lzc (
    .in_i    (enc_mant),
    .cnt_o   (shamt),
    .empty_o (mant_zero)
  );

  // Float mantissa sits at the LSB end, so add back the padding width
  assign fp_exp = fpcast_fmt_pkg::EXP_INT_WIDTH'(exp_field)
                + fpcast_fmt_pkg::EXP_INT_WIDTH'(info.is_subnormal)
                - fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::BIAS)
                - fpcast_fmt_pkg::EXP_INT_WIDTH'(shamt)
                + fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::MAN_INT_WIDTH - 1
                                                 - fpcast_fmt_pkg::MAN_BITS);
  assign int_exp = fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::MAN_INT_WIDTH - 1)
                 - fpcast_fmt_pkg::EXP_INT_WIDTH'(shamt);
  assign unb_exp = src_is_int ? int_exp : fp_exp;

  always_comb begin
    beat.sign        = src_is_int ? int_sign : operand_q[fpcast_fmt_pkg::FP_WIDTH-1];
    beat.exp         = unb_exp;
    beat.dst_exp     = unb_exp + fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::BIAS);
    beat.mant        = enc_mant << shamt;
    beat.mant_zero   = mant_zero;
    beat.info        = info;
    beat.op          = op_q;
    beat.is_unsigned = unsigned_q;
    beat.rnd_mode    = rnd_mode_q;
  end

  assign out_o.valid   = valid_q;
  assign out_o.payload = beat;

endmodule

`default_nettype wire

// ==== verilog/fpcast_align.sv ====
// Middle stage: range checks and the denormalizing shift
// Unsigned integers have one more bit of range than signed ones
`timescale 1ns/10ps
`default_nettype none

module fpcast_align (
  input  logic        clk_i,
  input  logic        rst_n_i,
  fpcast_stage_if.dst in_i,
  fpcast_stage_if.src out_o
);

  logic                      valid_q;
  fpcast_op_pkg::norm_beat_t beat_q;

  assign in_i.ready = out_o.ready | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_i.ready) begin
      valid_q <= in_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_i.ready && in_i.valid) begin
      beat_q <= in_i.payload;
    end
  end

  // ---------------------------------------------------------------------
  // Range checks before rounding
  // ---------------------------------------------------------------------
  logic                                            dst_is_int;
  logic signed [fpcast_fmt_pkg::EXP_INT_WIDTH-1:0] int_limit;
  logic        [fpcast_fmt_pkg::EXP_INT_WIDTH-1:0] denorm_shamt;
  logic        [fpcast_fmt_pkg::EXP_BITS-1:0]      final_exp;
  logic        [2*fpcast_fmt_pkg::MAN_INT_WIDTH:0] preshift_mant, dest_mant;
  logic                                            of_before, uf_before;

  assign dst_is_int = (beat_q.op == fpcast_op_pkg::F2I);
  assign int_limit  = fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::INT_WIDTH - 1)
                    + fpcast_fmt_pkg::EXP_INT_WIDTH'(beat_q.is_unsigned);

  always_comb begin
    final_exp     = beat_q.dst_exp[fpcast_fmt_pkg::EXP_BITS-1:0];
    preshift_mant = {beat_q.mant, {(fpcast_fmt_pkg::MAN_INT_WIDTH + 1){1'b0}}};
    denorm_shamt  = '0;
    of_before     = 1'b0;
    uf_before     = 1'b0;
    if (dst_is_int) begin
      denorm_shamt = fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::INT_WIDTH - 1)
                   - beat_q.exp;                  // Binary point to integer position
      if (beat_q.exp >= int_limit) begin
        denorm_shamt = '0;
        of_before    = 1'b1;
      end else if (beat_q.exp < -1) begin
        denorm_shamt = fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::INT_WIDTH + 1);
        uf_before    = 1'b1;                      // Everything lands in sticky
      end
    end else begin
      if (beat_q.dst_exp >= int'(2**fpcast_fmt_pkg::EXP_BITS - 1)) begin
        final_exp     = fpcast_fmt_pkg::EXP_BITS'(2**fpcast_fmt_pkg::EXP_BITS - 2);
        preshift_mant = '1;                       // Largest normal with R and S set
        of_before     = 1'b1;
      end else if (beat_q.dst_exp < 1) begin
        final_exp = '0;                           // Subnormal result
        uf_before = 1'b1;
        if (beat_q.dst_exp >= -int'(fpcast_fmt_pkg::MAN_BITS)) begin
          denorm_shamt = fpcast_fmt_pkg::EXP_INT_WIDTH'(1 - beat_q.dst_exp);
        end else begin
          denorm_shamt = fpcast_fmt_pkg::EXP_INT_WIDTH'(fpcast_fmt_pkg::MAN_BITS + 2);
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Shift and round/sticky extraction
  // ---------------------------------------------------------------------
  logic [fpcast_fmt_pkg::MAN_BITS-1:0]  final_mant;
  logic [fpcast_fmt_pkg::INT_WIDTH-1:0] final_int;
  logic [1:0]                           fp_rs, int_rs;
  fpcast_op_pkg::align_beat_t           beat;

  assign dest_mant = preshift_mant >> denorm_shamt;

  // Float drops the implicit bit at the top
  assign {final_mant, fp_rs[1]} =
      dest_mant[2*fpcast_fmt_pkg::MAN_INT_WIDTH-1 -: fpcast_fmt_pkg::MAN_BITS+1];
  assign {final_int, int_rs[1]} =
      dest_mant[2*fpcast_fmt_pkg::MAN_INT_WIDTH -: fpcast_fmt_pkg::INT_WIDTH+1];
  assign fp_rs[0]  = |dest_mant[2*fpcast_fmt_pkg::MAN_INT_WIDTH-fpcast_fmt_pkg::MAN_BITS-2:0];
  assign int_rs[0] = |dest_mant[2*fpcast_fmt_pkg::MAN_INT_WIDTH-fpcast_fmt_pkg::INT_WIDTH-1:0];

  always_comb begin
    beat.sign        = beat_q.sign;
    beat.final_exp   = final_exp;
    beat.value       = dst_is_int ? final_int : fpcast_fmt_pkg::INT_WIDTH'(final_mant);
    beat.fp_rs       = fp_rs;
    beat.int_rs      = int_rs;
    beat.of_before   = of_before;
    beat.uf_before   = uf_before;
    beat.info        = beat_q.info;
    beat.mant_zero   = beat_q.mant_zero;
    beat.op          = beat_q.op;
    beat.is_unsigned = beat_q.is_unsigned;
    beat.rnd_mode    = beat_q.rnd_mode;
  end

  assign out_o.valid   = valid_q;
  assign out_o.payload = beat;

endmodule

`default_nettype wire

// ==== verilog/fpcast_round.sv ====
// Output stage: rounding, special results and status flags
// result_o and status_o hold while out_ready_i is low
// Integer results saturate and raise NV on overflow or NaN input
`timescale 1ns/10ps
`default_nettype none

module fpcast_round (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  fpcast_stage_if.dst                         in_i,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic [fpcast_fmt_pkg::FP_WIDTH-1:0] result_o,
  output fpcast_op_pkg::status_t              status_o
);

  logic                       valid_q;
  fpcast_op_pkg::align_beat_t beat_q;

  assign in_i.ready  = out_ready_i | ~valid_q;
  assign out_valid_o = valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_i.ready) begin
      valid_q <= in_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_i.ready && in_i.valid) begin
      beat_q <= in_i.payload;
    end
  end

  // ---------------------------------------------------------------------
  // Rounding
  // ---------------------------------------------------------------------
  logic                                dst_is_int, src_is_int;
  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] pre_round_abs, rounded_abs;
  logic [1:0]                          rs;
  logic                                round_up;

  assign dst_is_int    = (beat_q.op == fpcast_op_pkg::F2I);
  assign src_is_int    = (beat_q.op == fpcast_op_pkg::I2F);
  assign pre_round_abs = dst_is_int ? beat_q.value
                       : {1'b0, beat_q.final_exp, beat_q.value[fpcast_fmt_pkg::MAN_BITS-1:0]};
  assign rs            = dst_is_int ? beat_q.int_rs : beat_q.fp_rs;

  always_comb begin
    case (beat_q.rnd_mode)
      fpcast_op_pkg::RNE: round_up = rs[1] & (rs[0] | pre_round_abs[0]);  // Ties to even
      fpcast_op_pkg::RTZ: round_up = 1'b0;
      fpcast_op_pkg::RDN: round_up = (|rs) & beat_q.sign;
      fpcast_op_pkg::RUP: round_up = (|rs) & ~beat_q.sign;
      default:            round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + fpcast_fmt_pkg::FP_WIDTH'(round_up);

  // ---------------------------------------------------------------------
  // Float result
  // ---------------------------------------------------------------------
  logic                                of_after, uf_after;
  logic                                fp_special;
  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] fp_result;
  fpcast_op_pkg::status_t              fp_status;

  assign uf_after = rounded_abs[fpcast_fmt_pkg::FP_WIDTH-2 -: fpcast_fmt_pkg::EXP_BITS] == '0;
  assign of_after = rounded_abs[fpcast_fmt_pkg::FP_WIDTH-2 -: fpcast_fmt_pkg::EXP_BITS] == '1;

  // Zero and NaN are special only when the source is a float
  assign fp_special = ~src_is_int & (beat_q.info.is_zero | beat_q.info.is_nan);

  always_comb begin
    if (fp_special) begin
      fp_result = beat_q.info.is_zero ? {beat_q.sign, {(fpcast_fmt_pkg::FP_WIDTH-1){1'b0}}}
                                      : fpcast_fmt_pkg::FP_QNAN;
      fp_status    = '0;
      fp_status.NV = beat_q.info.is_signalling;
    end else begin
      fp_result = (src_is_int & beat_q.mant_zero) ? '0  // Integer zero gives +0.0
                : {beat_q.sign, rounded_abs[fpcast_fmt_pkg::FP_WIDTH-2:0]};
      fp_status.NV = src_is_int & (beat_q.of_before | of_after);
      fp_status.DZ = 1'b0;
      fp_status.OF = ~src_is_int & ~beat_q.info.is_inf & (beat_q.of_before | of_after);
      fp_status.NX = (|beat_q.fp_rs)
                   | (~src_is_int & ~beat_q.info.is_inf & (beat_q.of_before | of_after));
      fp_status.UF = beat_q.uf_before & uf_after & fp_status.NX;  // Tiny after rounding
    end
  end

  // ---------------------------------------------------------------------
  // Integer result
  // ---------------------------------------------------------------------
  logic [fpcast_fmt_pkg::INT_WIDTH-1:0] int_res, sat_res, int_result;
  logic                                 int_special;
  fpcast_op_pkg::status_t               int_status;

  assign int_res = beat_q.sign ? -rounded_abs : rounded_abs;  // Two's complement

  // Positive max, or its inverse for negative values other than NaN
  assign sat_res = {(fpcast_fmt_pkg::INT_WIDTH){beat_q.sign & ~beat_q.info.is_nan}}
                 ^ {beat_q.is_unsigned, {(fpcast_fmt_pkg::INT_WIDTH-1){1'b1}}};

  assign int_special = beat_q.info.is_nan | beat_q.info.is_inf | beat_q.of_before
                     | (beat_q.sign & beat_q.is_unsigned & (int_res != '0));

  always_comb begin
    int_status = '0;
    if (int_special) begin
      int_result    = sat_res;
      int_status.NV = 1'b1;
    end else begin
      int_result    = int_res;
      int_status.NX = |beat_q.int_rs;
    end
  end

  assign result_o = dst_is_int ? int_result : fp_result;
  assign status_o = dst_is_int ? int_status : fp_status;

endmodule

`default_nettype wire

// ==== verilog/fpcast_top.sv ====
// Pipelined cast between IEEE binary32 and 32-bit integers
// Three register slots, one beat per cycle, ready is combinational
// Results appear three cycles after a beat is accepted
`timescale 1ns/10ps
`default_nettype none

module fpcast_top (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Request side
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  input  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] operand_i,
  input  fpcast_op_pkg::cast_op_e             op_i,
  input  logic                                unsigned_i,
  input  fpcast_op_pkg::round_mode_e          rnd_mode_i,
  // Response side
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic [fpcast_fmt_pkg::FP_WIDTH-1:0] result_o,
  output fpcast_op_pkg::status_t              status_o,
  output logic                                busy_o
);

  fpcast_stage_if #(.payload_t(fpcast_op_pkg::norm_beat_t))  norm2align ();
  fpcast_stage_if #(.payload_t(fpcast_op_pkg::align_beat_t)) align2round ();

  fpcast_normalize i_normalize (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .operand_i  (operand_i),
    .op_i       (op_i),
    .unsigned_i (unsigned_i),
    .rnd_mode_i (rnd_mode_i),
    .out_o      (norm2align.src)
  );

  fpcast_align i_align (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .in_i    (norm2align.dst),
    .out_o   (align2round.src)
  );

  fpcast_round i_round (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_i        (align2round.dst),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o)
  );

  // Each link valid is the slot valid of the stage driving it
  assign busy_o = norm2align.valid | align2round.valid | out_valid_o;

endmodule

`default_nettype wire

// ==== dv/fpcast_vectors.svh ====
// Stimulus table and typed compare tasks for the cast unit testbench
// Included inside the testbench module; needs error_count declared first
// Expected values follow IEEE binary32 rounding and saturation rules
`ifndef FPCAST_VECTORS_SVH
`define FPCAST_VECTORS_SVH

  localparam fpcast_op_pkg::cast_op_e    OP_F2I = fpcast_op_pkg::F2I;
  localparam fpcast_op_pkg::cast_op_e    OP_I2F = fpcast_op_pkg::I2F;
  localparam fpcast_op_pkg::round_mode_e RM_RNE = fpcast_op_pkg::RNE;
  localparam fpcast_op_pkg::round_mode_e RM_RTZ = fpcast_op_pkg::RTZ;
  localparam fpcast_op_pkg::round_mode_e RM_RDN = fpcast_op_pkg::RDN;
  localparam fpcast_op_pkg::round_mode_e RM_RUP = fpcast_op_pkg::RUP;

  // Flag order is NV DZ OF UF NX
  localparam fpcast_op_pkg::status_t ST_NONE = 5'b00000;
  localparam fpcast_op_pkg::status_t ST_NX   = 5'b00001;
  localparam fpcast_op_pkg::status_t ST_NV   = 5'b10000;

  typedef struct packed {
    logic [fpcast_fmt_pkg::FP_WIDTH-1:0] operand;
    fpcast_op_pkg::cast_op_e             op;
    logic                                is_unsigned;
    fpcast_op_pkg::round_mode_e          rnd_mode;
    logic [fpcast_fmt_pkg::FP_WIDTH-1:0] exp_result;
    fpcast_op_pkg::status_t              exp_status;
  } vector_t;

  localparam int NUM_VECTORS = 31;

  // -------------------------------------------------------------------
  // operand, op, unsigned, rounding mode, expected result, expected flags
  // -------------------------------------------------------------------
  localparam vector_t VECTORS [NUM_VECTORS] = '{
    // Exact integers to float
    '{32'h0000_0000, OP_I2F, 1'b0, RM_RNE, 32'h0000_0000, ST_NONE},
    '{32'hFFFF_FFFF, OP_I2F, 1'b0, RM_RNE, 32'hBF80_0000, ST_NONE},  // -1
    '{32'h0000_0001, OP_I2F, 1'b0, RM_RNE, 32'h3F80_0000, ST_NONE},
    '{32'hFFFF_FF00, OP_I2F, 1'b1, RM_RNE, 32'h4F7F_FFFF, ST_NONE},  // 24 bits, unsigned
    '{32'h8000_0000, OP_I2F, 1'b0, RM_RNE, 32'hCF00_0000, ST_NONE},  // -2^31
    // 2^24+1 is a tie between two floats
    '{32'h0100_0001, OP_I2F, 1'b0, RM_RNE, 32'h4B80_0000, ST_NX},
    '{32'h0100_0001, OP_I2F, 1'b0, RM_RTZ, 32'h4B80_0000, ST_NX},
    '{32'h0100_0001, OP_I2F, 1'b0, RM_RUP, 32'h4B80_0001, ST_NX},
    '{32'h0100_0001, OP_I2F, 1'b0, RM_RDN, 32'h4B80_0000, ST_NX},
    '{32'hFEFF_FFFF, OP_I2F, 1'b0, RM_RNE, 32'hCB80_0000, ST_NX},
    '{32'hFEFF_FFFF, OP_I2F, 1'b0, RM_RTZ, 32'hCB80_0000, ST_NX},
    '{32'hFEFF_FFFF, OP_I2F, 1'b0, RM_RUP, 32'hCB80_0000, ST_NX},
    '{32'hFEFF_FFFF, OP_I2F, 1'b0, RM_RDN, 32'hCB80_0001, ST_NX},
    '{32'hFFFF_FFFF, OP_I2F, 1'b1, RM_RNE, 32'h4F80_0000, ST_NX},  // Rounds up to 2^32
    // 2.5 and -2.5 to integer
    '{32'h4020_0000, OP_F2I, 1'b0, RM_RNE, 32'h0000_0002, ST_NX},
    '{32'h4020_0000, OP_F2I, 1'b0, RM_RTZ, 32'h0000_0002, ST_NX},
    '{32'h4020_0000, OP_F2I, 1'b0, RM_RUP, 32'h0000_0003, ST_NX},
    '{32'h4020_0000, OP_F2I, 1'b0, RM_RDN, 32'h0000_0002, ST_NX},
    '{32'hC020_0000, OP_F2I, 1'b0, RM_RDN, 32'hFFFF_FFFD, ST_NX},
    '{32'hC020_0000, OP_F2I, 1'b0, RM_RNE, 32'hFFFF_FFFE, ST_NX},
    // Invalid conversions saturate
    '{32'h7FC0_0000, OP_F2I, 1'b0, RM_RNE, 32'h7FFF_FFFF, ST_NV},  // NaN
    '{32'h7FC0_0000, OP_F2I, 1'b1, RM_RNE, 32'hFFFF_FFFF, ST_NV},
    '{32'h7F80_0000, OP_F2I, 1'b0, RM_RNE, 32'h7FFF_FFFF, ST_NV},  // +inf
    '{32'h7F80_0000, OP_F2I, 1'b1, RM_RNE, 32'hFFFF_FFFF, ST_NV},
    '{32'hFF80_0000, OP_F2I, 1'b0, RM_RNE, 32'h8000_0000, ST_NV},  // -inf
    '{32'h4F32_D05E, OP_F2I, 1'b0, RM_RNE, 32'h7FFF_FFFF, ST_NV},  // 3e9 signed
    '{32'h4F32_D05E, OP_F2I, 1'b1, RM_RNE, 32'hB2D0_5E00, ST_NONE},
    '{32'hBFC0_0000, OP_F2I, 1'b1, RM_RNE, 32'h0000_0000, ST_NV},  // -1.5 unsigned
    '{32'hBE80_0000, OP_F2I, 1'b1, RM_RTZ, 32'h0000_0000, ST_NX},  // -0.25 unsigned
    '{32'h0000_0000, OP_F2I, 1'b0, RM_RNE, 32'h0000_0000, ST_NONE},
    '{32'h3F80_0000, OP_F2I, 1'b0, RM_RNE, 32'h0000_0001, ST_NONE}
  };

  // -------------------------------------------------------------------
  // Typed compares
  // -------------------------------------------------------------------
  task automatic compare_result(input int                                  row,
                                input logic [fpcast_fmt_pkg::FP_WIDTH-1:0] got,
                                input logic [fpcast_fmt_pkg::FP_WIDTH-1:0] want);
    if (got !== want) begin
      $display("ERROR %0t: row %0d result %08h, expected %08h", $time, row, got, want);
      error_count++;
    end
  endtask

  task automatic verify_status(input int                     row,
                               input fpcast_op_pkg::status_t got,
                               input fpcast_op_pkg::status_t want);
    if (got !== want) begin
      $display("ERROR %0t: row %0d flags NV DZ OF UF NX = %05b, expected %05b",
               $time, row, got, want);
      error_count++;
    end
  endtask

`endif

// ==== dv/fpcast_tb.sv ====
// Testbench for the binary32 <-> 32-bit integer cast unit
// Applies the vector table in order under random output back-pressure
`timescale 1ns/10ps
`default_nettype none

module fpcast_tb;

  localparam int CLK_PERIOD = 4;

  logic                                clk;
  logic                                rst_n;
  logic                                in_valid;
  logic                                in_ready;
  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] operand;
  fpcast_op_pkg::cast_op_e             op;
  logic                                is_unsigned;
  fpcast_op_pkg::round_mode_e          rnd_mode;
  logic                                out_valid;
  logic                                out_ready;
  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] result;
  fpcast_op_pkg::status_t              status;
  logic                                busy;

  int                                  error_count;
  int                                  received;
  int                                  pending [$];  // Rows accepted, oldest first
  logic                                hold_pending;
  logic [fpcast_fmt_pkg::FP_WIDTH-1:0] held_result;
  fpcast_op_pkg::status_t              held_status;

  `include "fpcast_vectors.svh"

  fpcast_top dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .operand_i   (operand),
    .op_i        (op),
    .unsigned_i  (is_unsigned),
    .rnd_mode_i  (rnd_mode),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .status_o    (status),
    .busy_o      (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Random back-pressure, ready about three cycles in four
  initial begin
    void'($urandom(54857));
    forever begin
      @(posedge clk);
      out_ready <= ($urandom % 4) != 0;
    end
  end

  // -------------------------------------------------------------------
  // Stimulus and final summary
  // -------------------------------------------------------------------
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    operand      = '0;
    op           = OP_F2I;
    is_unsigned  = 1'b0;
    rnd_mode     = RM_RNE;
    out_ready    = 1'b0;
    error_count  = 0;
    received     = 0;
    hold_pending = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (out_valid !== 1'b0 || busy !== 1'b0 || in_ready !== 1'b1) begin
      $display("ERROR %0t: unit not idle after reset", $time);
      error_count++;
    end
    for (int i = 0; i < NUM_VECTORS; i++) begin
      in_valid    <= 1'b1;
      operand     <= VECTORS[i].operand;
      op          <= VECTORS[i].op;
      is_unsigned <= VECTORS[i].is_unsigned;
      rnd_mode    <= VECTORS[i].rnd_mode;
      @(posedge clk);
      while (!in_ready) @(posedge clk);  // Hold until accepted
      pending.push_back(i);
    end
    in_valid <= 1'b0;
    wait (received == NUM_VECTORS);
    @(posedge clk);
    if (busy !== 1'b0 || out_valid !== 1'b0) begin
      $display("ERROR %0t: busy_o or out_valid_o high after the last output", $time);
      error_count++;
    end
    $display("Rows: %0d, received: %0d, errors: %0d", NUM_VECTORS, received, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // -------------------------------------------------------------------
  // Output collection
  // -------------------------------------------------------------------
  always @(posedge clk) begin
    int row;
    int errors_before;
    if (rst_n) begin
      if (hold_pending && (result !== held_result || status !== held_status)) begin
        $display("ERROR %0t: output changed while out_ready_i was low", $time);
        error_count++;
      end
      hold_pending = out_valid && !out_ready;
      held_result  = result;
      held_status  = status;
      if (out_valid && out_ready) begin
        if (pending.size() == 0) begin
          $display("Output at %0t has no matching request", $time);
          error_count++;
        end else begin
          row           = pending.pop_front();
          errors_before = error_count;
          compare_result(row, result, VECTORS[row].exp_result);
          verify_status(row, status, VECTORS[row].exp_status);
          $display("Row %0d: %s", row, (error_count == errors_before) ? "ok" : "mismatch");
          received++;
        end
      end
    end
  end

  // Twenty cycles per row is far more than the pipeline needs
  initial begin
    #(NUM_VECTORS * 20 * CLK_PERIOD);
    $display("Timeout: only %0d of %0d rows came out", received, NUM_VECTORS);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+dv
verilog/fpcast_fmt_pkg.sv
verilog/fpcast_op_pkg.sv
verilog/fpcast_stage_if.sv
verilog/fpcast_lzc.sv
verilog/fpcast_normalize.sv
verilog/fpcast_align.sv
verilog/fpcast_round.sv
verilog/fpcast_top.sv
dv/fpcast_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cast unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module fpcast_tb -f vlog.f -o fpcast_sim
./obj_dir/fpcast_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
grep -q "sim passed" sim.log
